/* rtl/buf_cfg.svh */
`ifndef BUF_CFG_SVH
`define BUF_CFG_SVH

// halfword width
`define DATA_W        16
// buffer geometry
`define PAGE_WORDS    8
`define NUM_PAGES     32
`define NUM_QUEUES    8
// eight full pages
`define MAX_PKT_WORDS 64
// full while fewer free pages than one longest packet
`define FULL_PAGES    8

`endif

/* rtl/pkt_fmt_pkg.sv */
package pkt_fmt_pkg;

    // priority 0 is the most urgent
    typedef enum logic [2:0] {
        PRIO_0 = 3'd0,
        PRIO_1 = 3'd1,
        PRIO_2 = 3'd2,
        PRIO_3 = 3'd3,
        PRIO_4 = 3'd4,
        PRIO_5 = 3'd5,
        PRIO_6 = 3'd6,
        PRIO_7 = 3'd7
    } prio_t;

    // first halfword of every packet, length counts the header too
    typedef struct packed {
        logic [8:0] len;
        logic [3:0] spare;
        prio_t      prio;
    } pkt_hdr_t;

endpackage

/* rtl/buf_types_pkg.sv */
`include "buf_cfg.svh"

package buf_types_pkg;
    import pkt_fmt_pkg::*;

    localparam int PAGE_ID_W  = $clog2(`NUM_PAGES);
    localparam int OFFSET_W   = $clog2(`PAGE_WORDS);
    localparam int QUEUE_ID_W = $clog2(`NUM_QUEUES);

    typedef logic [PAGE_ID_W-1:0]          page_id_t;
    typedef logic [OFFSET_W-1:0]           page_off_t;
    // page number in the upper bits, halfword offset below
    typedef logic [PAGE_ID_W+OFFSET_W-1:0] word_addr_t;
    typedef logic [QUEUE_ID_W-1:0]         queue_id_t;

    // one stored packet
    typedef struct packed {
        prio_t    prio;
        page_id_t head;
        page_id_t tail;
    } pkt_desc_t;

    // link table write from the ingress side
    typedef struct packed {
        logic     en;
        page_id_t from_page;
        page_id_t to_page;
    } link_wr_t;

    typedef enum logic [1:0] {WR_IDLE, WR_BODY, WR_FINISH} wr_state_t;

    typedef enum logic {RD_IDLE, RD_STREAM} rd_state_t;

endpackage

/* rtl/page_store.sv */
`timescale 1ns/100ps
`include "buf_cfg.svh"

module page_store
    import buf_types_pkg::*;
(
    input  logic               clk,
    input  logic               wr_en,
    input  word_addr_t         wr_addr,
    input  logic [`DATA_W-1:0] wr_data,
    input  logic               rd_en,
    input  word_addr_t         rd_addr,
    output logic [`DATA_W-1:0] rd_data
);
    // all pages back to back, one halfword per address
    logic [`DATA_W-1:0] mem [`NUM_PAGES*`PAGE_WORDS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // registered read, data one cycle after the address
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* rtl/free_page_list.sv */
`timescale 1ns/100ps
`include "buf_cfg.svh"

module free_page_list
    import buf_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     alloc,
    output page_id_t alloc_page,
    input  logic     release_en,
    input  page_id_t release_page,
    output logic     full
);
    localparam int CNT_W = $clog2(`NUM_PAGES + 1);

    page_id_t         ids [`NUM_PAGES];
    page_id_t         rd_ptr;
    page_id_t         wr_ptr;
    logic [CNT_W-1:0] free_cnt;
    logic [CNT_W-1:0] free_cnt_next;

    // head of the list is always on show
    assign alloc_page = ids[rd_ptr];

    always_comb begin
        free_cnt_next = free_cnt;
        if (alloc && !release_en) begin
            free_cnt_next = free_cnt - 1'b1;
        end else if (release_en && !alloc) begin
            free_cnt_next = free_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            free_cnt <= CNT_W'(`NUM_PAGES);
            full     <= 1'b0;
        end else begin
            if (alloc) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (release_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            free_cnt <= free_cnt_next;
            full     <= free_cnt_next < CNT_W'(`FULL_PAGES);
        end
    end

    // every page starts out free, in order
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_PAGES; i++) begin
                ids[i] <= page_id_t'(i);
            end
        end else if (release_en) begin
            ids[wr_ptr] <= release_page;
        end
    end

endmodule

/* rtl/ingress_writer.sv */
`timescale 1ns/100ps
`include "buf_cfg.svh"

module ingress_writer
    import buf_types_pkg::*;
    import pkt_fmt_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_sop,
    input  logic               wr_eop,
    input  logic               wr_vld,
    input  logic [`DATA_W-1:0] wr_data,
    output logic               alloc,
    input  page_id_t           alloc_page,
    output logic               mem_wr_en,
    output word_addr_t         mem_wr_addr,
    output logic [`DATA_W-1:0] mem_wr_data,
    output link_wr_t           link_wr,
    output logic               append,
    output pkt_desc_t          append_desc
);
    wr_state_t state;
    wr_state_t state_next;
    page_off_t word_off;
    page_off_t beat_off;
    page_id_t  cur_page;
    page_id_t  beat_page;
    page_id_t  head_page;
    prio_t     prio;
    pkt_hdr_t  hdr;
    logic      beat;
    logic      new_page;

    assign hdr = pkt_hdr_t'(wr_data);

    // outside a packet only a sop beat is taken
    assign beat      = wr_vld && (state == WR_BODY || wr_sop);
    assign beat_off  = (state == WR_BODY) ? word_off : '0;
    assign new_page  = beat && beat_off == '0;
    assign beat_page = new_page ? alloc_page : cur_page;

    assign alloc       = new_page;
    assign mem_wr_en   = beat;
    assign mem_wr_addr = {beat_page, beat_off};
    assign mem_wr_data = wr_data;

    // chain the filled page to the fresh one
    assign link_wr.en        = new_page && state == WR_BODY;
    assign link_wr.from_page = cur_page;
    assign link_wr.to_page   = alloc_page;

    // cur_page still holds the page of the eop beat here
    assign append           = state == WR_FINISH;
    assign append_desc.prio = prio;
    assign append_desc.head = head_page;
    assign append_desc.tail = cur_page;

    always_comb begin
        state_next = state;
        case (state)
            WR_IDLE, WR_FINISH: begin
                if (beat) begin
                    state_next = wr_eop ? WR_FINISH : WR_BODY;
                end else begin
                    state_next = WR_IDLE;
                end
            end
            WR_BODY: begin
                if (beat && wr_eop) begin
                    state_next = WR_FINISH;
                end
            end
            default: state_next = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= WR_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            word_off <= beat_off + 1'b1;
            cur_page <= beat_page;
        end
        // header beat
        if (beat && state != WR_BODY) begin
            head_page <= alloc_page;
            prio      <= hdr.prio;
        end
    end

endmodule

/* rtl/queue_manager.sv */
`timescale 1ns/100ps
`include "buf_cfg.svh"

module queue_manager
    import buf_types_pkg::*;
    import pkt_fmt_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  link_wr_t  link_wr,
    input  logic      append,
    input  pkt_desc_t append_desc,
    output logic      not_empty,
    input  logic      pop,
    output pkt_desc_t head_desc,
    input  page_id_t  link_rd_page,
    output page_id_t  link_next
);
    // next page inside a packet, or next packet head on a tail page
    page_id_t link_tbl [`NUM_PAGES];
    // tail page of the packet that starts at the index
    page_id_t tail_tbl [`NUM_PAGES];
    page_id_t q_head [`NUM_QUEUES];
    page_id_t q_tail [`NUM_QUEUES];
    logic [`NUM_QUEUES-1:0] q_valid;
    queue_id_t sel;
    queue_id_t app_q;
    logic      pop_last;
    logic      app_new_head;

    assign link_next = link_tbl[link_rd_page];
    assign not_empty = |q_valid;
    assign app_q     = queue_id_t'(append_desc.prio);

    // strict priority, lowest number wins
    always_comb begin
        sel = '0;
        for (int q = `NUM_QUEUES - 1; q >= 0; q--) begin
            if (q_valid[q]) begin
                sel = queue_id_t'(q);
            end
        end
    end

    assign head_desc.prio = prio_t'(sel);
    assign head_desc.head = q_head[sel];
    assign head_desc.tail = tail_tbl[q_head[sel]];

    assign pop_last = head_desc.tail == q_tail[sel];
    // empty queue, or its only packet leaves in this cycle
    assign app_new_head = !q_valid[app_q] || (pop && pop_last && sel == app_q);

    always_ff @(posedge clk) begin
        if (link_wr.en) begin
            link_tbl[link_wr.from_page] <= link_wr.to_page;
        end
        if (append && q_valid[app_q]) begin
            link_tbl[q_tail[app_q]] <= append_desc.head;
        end
        if (append) begin
            tail_tbl[append_desc.head] <= append_desc.tail;
        end
    end

    always_ff @(posedge clk) begin
        if (pop && !pop_last) begin
            q_head[sel] <= link_tbl[head_desc.tail];
        end
        if (append) begin
            q_tail[app_q] <= append_desc.tail;
            if (app_new_head) begin
                q_head[app_q] <= append_desc.head;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_valid <= '0;
        end else begin
            if (pop && pop_last) begin
                q_valid[sel] <= 1'b0;
            end
            // append wins over a pop of the same queue
            if (append) begin
                q_valid[app_q] <= 1'b1;
            end
        end
    end

endmodule

/* rtl/egress_reader.sv */
`timescale 1ns/100ps
`include "buf_cfg.svh"

module egress_reader
    import buf_types_pkg::*;
    import pkt_fmt_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ready,
    input  logic               not_empty,
    output logic               pop,
    input  pkt_desc_t          head_desc,
    output logic               mem_rd_en,
    output word_addr_t         mem_rd_addr,
    input  logic [`DATA_W-1:0] mem_rd_data,
    output page_id_t           link_rd_page,
    input  page_id_t           link_next,
    output logic               release_en,
    output page_id_t           release_page,
    output logic               rd_sop,
    output logic               rd_eop,
    output logic               rd_vld,
    output logic [`DATA_W-1:0] rd_data
);
    rd_state_t  state;
    page_id_t   rd_page;
    page_id_t   issue_page;
    page_off_t  rd_off;
    logic [8:0] left;
    logic [8:0] left_now;
    logic       hdr_wait;
    logic       out_vld;
    logic       last_q;
    logic       issue;
    logic       page_end;
    pkt_hdr_t   hdr;

    assign hdr = pkt_hdr_t'(mem_rd_data);

    // ready only counts between packets
    assign pop = state == RD_IDLE && ready && not_empty;

    // length becomes known when the header returns
    assign left_now = hdr_wait ? hdr.len - 1'b1 : left;
    assign issue    = state == RD_STREAM && left_now != '0;

    // offset zero means the previous page is used up
    assign link_rd_page = rd_page;
    assign issue_page   = (rd_off == '0) ? link_next : rd_page;
    assign page_end     = rd_off == page_off_t'(`PAGE_WORDS - 1);

    assign mem_rd_en   = pop || issue;
    assign mem_rd_addr = pop ? {head_desc.head, page_off_t'(0)} : {issue_page, rd_off};

    // page is freed with the read of its last halfword
    assign release_en   = (hdr_wait && hdr.len == 9'd1) ||
                          (issue && (page_end || left_now == 9'd1));
    assign release_page = issue_page;

    assign rd_vld  = out_vld;
    assign rd_sop  = hdr_wait;
    assign rd_eop  = last_q || (hdr_wait && hdr.len == 9'd1);
    assign rd_data = mem_rd_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= RD_IDLE;
            hdr_wait <= 1'b0;
            out_vld  <= 1'b0;
            last_q   <= 1'b0;
        end else begin
            out_vld  <= mem_rd_en;
            hdr_wait <= pop;
            last_q   <= issue && left_now == 9'd1;
            case (state)
                RD_IDLE: begin
                    if (pop) begin
                        state <= RD_STREAM;
                    end
                end
                RD_STREAM: begin
                    // final halfword is on the output now
                    if (!issue) begin
                        state <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rd_page <= head_desc.head;
            rd_off  <= page_off_t'(1);
        end else if (issue) begin
            rd_page <= issue_page;
            rd_off  <= rd_off + 1'b1;
            left    <= left_now - 1'b1;
        end
    end

endmodule

/* rtl/pkt_buf_top.sv */
`timescale 1ns/100ps
`include "buf_cfg.svh"

module pkt_buf_top
    import buf_types_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_sop,
    input  logic               wr_eop,
    input  logic               wr_vld,
    input  logic [`DATA_W-1:0] wr_data,
    output logic               full,
    input  logic               ready,
    output logic               rd_sop,
    output logic               rd_eop,
    output logic               rd_vld,
    output logic [`DATA_W-1:0] rd_data
);
    logic               alloc;
    page_id_t           alloc_page;
    logic               release_en;
    page_id_t           release_page;
    logic               mem_wr_en;
    word_addr_t         mem_wr_addr;
    logic [`DATA_W-1:0] mem_wr_data;
    logic               mem_rd_en;
    word_addr_t         mem_rd_addr;
    logic [`DATA_W-1:0] mem_rd_data;
    link_wr_t           link_wr;
    logic               append;
    pkt_desc_t          append_desc;
    logic               not_empty;
    logic               pop;
    pkt_desc_t          head_desc;
    page_id_t           link_rd_page;
    page_id_t           link_next;

    ingress_writer u_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_sop      (wr_sop),
        .wr_eop      (wr_eop),
        .wr_vld      (wr_vld),
        .wr_data     (wr_data),
        .alloc       (alloc),
        .alloc_page  (alloc_page),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .link_wr     (link_wr),
        .append      (append),
        .append_desc (append_desc)
    );

    egress_reader u_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .ready        (ready),
        .not_empty    (not_empty),
        .pop          (pop),
        .head_desc    (head_desc),
        .mem_rd_en    (mem_rd_en),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_data  (mem_rd_data),
        .link_rd_page (link_rd_page),
        .link_next    (link_next),
        .release_en   (release_en),
        .release_page (release_page),
        .rd_sop       (rd_sop),
        .rd_eop       (rd_eop),
        .rd_vld       (rd_vld),
        .rd_data      (rd_data)
    );

    queue_manager u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .link_wr      (link_wr),
        .append       (append),
        .append_desc  (append_desc),
        .not_empty    (not_empty),
        .pop          (pop),
        .head_desc    (head_desc),
        .link_rd_page (link_rd_page),
        .link_next    (link_next)
    );

    free_page_list u_free_list (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .alloc_page   (alloc_page),
        .release_en   (release_en),
        .release_page (release_page),
        .full         (full)
    );

    page_store u_store (
        .clk     (clk),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .rd_en   (mem_rd_en),
        .rd_addr (mem_rd_addr),
        .rd_data (mem_rd_data)
    );

endmodule

/* test/pkt_buf_chk.sv */
`timescale 1ns/100ps
`include "buf_cfg.svh"

module pkt_buf_chk (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              rd_sop,
    input logic                              rd_eop,
    input logic                              rd_vld,
    input logic                              alloc,
    input logic [$clog2(`NUM_PAGES + 1)-1:0] free_cnt
);
    // frame markers only on valid beats
    sop_with_vld: assert property (@(posedge clk) disable iff (!rst_n) rd_sop |-> rd_vld)
        else $error("rd_sop seen without rd_vld");

    eop_with_vld: assert property (@(posedge clk) disable iff (!rst_n) rd_eop |-> rd_vld)
        else $error("rd_eop seen without rd_vld");

    free_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
        free_cnt <= `NUM_PAGES)
        else $error("free page count above the number of pages");

    // allocation from an empty free list
    alloc_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        alloc |-> free_cnt != '0)
        else $error("page allocated while no page is free");

endmodule

bind pkt_buf_top pkt_buf_chk u_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_sop   (rd_sop),
    .rd_eop   (rd_eop),
    .rd_vld   (rd_vld),
    .alloc    (alloc),
    .free_cnt (u_free_list.free_cnt)
);

/* test/pkt_buf_tb.sv */
`timescale 1ns/100ps
`include "buf_cfg.svh"

module pkt_buf_tb
    import pkt_fmt_pkg::*;
();
    localparam int GOLD_DEPTH = 256;
    localparam int MAX_BATCH  = 8;

    // one expected or observed output beat
    typedef struct packed {
        logic               sop;
        logic               eop;
        logic [`DATA_W-1:0] data;
    } beat_t;

    logic               clk;
    logic               rst_n;
    logic               wr_sop;
    logic               wr_eop;
    logic               wr_vld;
    logic [`DATA_W-1:0] wr_data;
    logic               full;
    logic               ready;
    logic               rd_sop;
    logic               rd_eop;
    logic               rd_vld;
    logic [`DATA_W-1:0] rd_data;

    logic [15:0]        gold [GOLD_DEPTH];
    int                 gold_pos;
    int                 seed;
    int                 cycle_cnt = 0;
    int                 cycle_limit = 0;
    logic               in_pkt = 1'b0;
    int                 pkt_prio [MAX_BATCH];
    int                 pkt_len [MAX_BATCH];
    int                 drain_order [MAX_BATCH];
    logic [`DATA_W-1:0] pkt_words [MAX_BATCH][`MAX_PKT_WORDS];
    beat_t              exp_q [$];

    pkt_buf_top uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .full    (full),
        .ready   (ready),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic void stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "run stopped at the first error");
    endfunction

    function automatic int take_gold();
        logic [15:0] val;
        val = gold[gold_pos];
        assert (gold_pos < GOLD_DEPTH && !$isunknown(val))
            else stop_with_failure("golden file ends in the middle of a batch");
        gold_pos++;
        return int'(val);
    endfunction

    // total halfwords in the golden file
    function automatic int count_words();
        int pos;
        int sum;
        int n;
        pos = 0;
        sum = 0;
        while (pos < GOLD_DEPTH && !$isunknown(gold[pos]) && gold[pos] != '0) begin
            n = int'(gold[pos]);
            for (int i = 0; i < n; i++) begin
                sum += int'(gold[pos + 2 + 2 * i]);
            end
            pos += 1 + 3 * n;
        end
        return sum;
    endfunction

    // strict priority with arrival order inside one priority
    function automatic void check_order(input int n);
        int want [MAX_BATCH];
        int cnt;
        cnt = 0;
        for (int p = 0; p < `NUM_QUEUES; p++) begin
            for (int i = 0; i < n; i++) begin
                if (pkt_prio[i] == p) begin
                    want[cnt] = i;
                    cnt++;
                end
            end
        end
        for (int i = 0; i < n; i++) begin
            assert (drain_order[i] == want[i])
                else stop_with_failure($sformatf(
                    "golden drain order entry %0d is %0d, strict priority gives %0d",
                    i, drain_order[i], want[i]));
        end
    endfunction

    task automatic send_packet(input int idx);
        pkt_hdr_t    hdr;
        logic [31:0] rnd;
        // new packets only while full is low
        while (full) begin
            @(posedge clk);
            #1;
        end
        for (int w = 0; w < pkt_len[idx]; w++) begin
            rnd = $random(seed);
            if (w > 0 && rnd[18:16] == 3'd0) begin
                wr_vld = 1'b0;
                wr_sop = 1'b0;
                wr_eop = 1'b0;
                @(posedge clk);
                #1;
            end
            if (w == 0) begin
                hdr.len   = 9'(pkt_len[idx]);
                hdr.spare = rnd[3:0];
                hdr.prio  = prio_t'(pkt_prio[idx][2:0]);
                pkt_words[idx][w] = hdr;
            end else begin
                pkt_words[idx][w] = rnd[15:0];
            end
            wr_vld  = 1'b1;
            wr_sop  = (w == 0);
            wr_eop  = (w == pkt_len[idx] - 1);
            wr_data = pkt_words[idx][w];
            @(posedge clk);
            #1;
        end
        wr_vld = 1'b0;
        wr_sop = 1'b0;
        wr_eop = 1'b0;
    endtask

    // scoreboard of output beats against the expected queue
    always @(posedge clk) begin
        beat_t got;
        beat_t want;
        if (rst_n && rd_vld) begin
            got.sop  = rd_sop;
            got.eop  = rd_eop;
            got.data = rd_data;
            assert (exp_q.size() > 0)
                else stop_with_failure("DUT sent a halfword while no packet was expected");
            want = exp_q.pop_front();
            assert (got == want)
                else stop_with_failure($sformatf(
                    "mismatch at %0t: got sop %b eop %b data %h, expected sop %b eop %b data %h",
                    $time, got.sop, got.eop, got.data, want.sop, want.eop, want.data));
            in_pkt = !rd_eop;
        end else if (rst_n) begin
            // beats of one packet come back to back
            assert (!in_pkt)
                else stop_with_failure($sformatf(
                    "mismatch at %0t: rd_vld dropped inside a packet", $time));
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            stop_with_failure($sformatf("timeout after %0d cycles, the DUT stopped responding",
                cycle_cnt));
        end
    end

    initial begin
        int    n;
        int    idx;
        int    pages;
        int    batch;
        logic  expect_full;
        beat_t want;
        seed     = 70;
        rst_n    = 1'b0;
        wr_sop   = 1'b0;
        wr_eop   = 1'b0;
        wr_vld   = 1'b0;
        wr_data  = '0;
        ready    = 1'b0;
        gold_pos = 0;
        batch    = 0;
        $readmemh("test/pkt_buf_golden.txt", gold);
        cycle_limit = 40 * count_words() + 500;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        assert (!full && !rd_vld && !rd_sop && !rd_eop)
            else stop_with_failure($sformatf(
                "mismatch at %0t: outputs are not idle after reset", $time));
        n = take_gold();
        while (n != 0) begin
            assert (n <= MAX_BATCH)
                else stop_with_failure("golden batch holds more packets than supported");
            pages = 0;
            for (int i = 0; i < n; i++) begin
                pkt_prio[i] = take_gold();
                pkt_len[i]  = take_gold();
                assert (pkt_prio[i] < `NUM_QUEUES && pkt_len[i] >= 1 &&
                        pkt_len[i] <= `MAX_PKT_WORDS)
                    else stop_with_failure("golden packet has a bad priority or length");
                pages += (pkt_len[i] + `PAGE_WORDS - 1) / `PAGE_WORDS;
            end
            for (int i = 0; i < n; i++) begin
                drain_order[i] = take_gold();
            end
            check_order(n);
            for (int i = 0; i < n; i++) begin
                send_packet(i);
            end
            // last append lands the cycle after eop
            repeat (2) @(posedge clk);
            #1;
            expect_full = (`NUM_PAGES - pages) < `FULL_PAGES;
            assert (full == expect_full)
                else stop_with_failure($sformatf(
                    "mismatch at %0t: full is %b after batch %0d, expected %b",
                    $time, full, batch, expect_full));
            for (int i = 0; i < n; i++) begin
                idx = drain_order[i];
                for (int k = 0; k < pkt_len[idx]; k++) begin
                    want.sop  = (k == 0);
                    want.eop  = (k == pkt_len[idx] - 1);
                    want.data = pkt_words[idx][k];
                    exp_q.push_back(want);
                end
            end
            ready = 1'b1;
            while (exp_q.size() != 0) begin
                @(posedge clk);
                #1;
            end
            ready = 1'b0;
            repeat (2) @(posedge clk);
            #1;
            // every page back on the free list
            assert (!full)
                else stop_with_failure($sformatf(
                    "mismatch at %0t: full still high after draining batch %0d", $time, batch));
            batch++;
            n = take_gold();
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

/* project.f */
+incdir+rtl
rtl/pkt_fmt_pkg.sv
rtl/buf_types_pkg.sv
rtl/page_store.sv
rtl/free_page_list.sv
rtl/ingress_writer.sv
rtl/queue_manager.sv
rtl/egress_reader.sv
rtl/pkt_buf_top.sv
test/pkt_buf_chk.sv
test/pkt_buf_tb.sv

/* Makefile */
# Verilator flow for the shared-buffer packet queue

VERILATOR ?= verilator
TOP       ?= pkt_buf_tb
SEED      ?= 1
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the run prints the pass message
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* test/pkt_buf_golden.txt */
// per batch: packet count, one "priority length" pair per packet, then the
// expected drain order as packet indices; all values hex, a count of 00 ends the file
// one-page packet and a header-only packet
02
3 05
3 01
0 1
// one 64-halfword packet over eight pages
01
0 40
0
// mixed priorities, lengths 12 8 3 17 9
05
5 0c
2 08
7 03
0 11
4 09
3 1 4 0 2
// equal priorities keep arrival order, lengths 6 16 2 9
04
1 06
1 10
6 02
1 09
0 1 3 2
// four longest packets use every page and raise full
04
2 40
2 40
2 40
2 40
0 1 2 3
// runs on recycled pages, lengths 20 7 33 11 1 24
06
7 14
0 07
3 21
0 0b
5 01
3 18
1 3 2 5 4 0
00
